/* common/mips_params.svh */
// core-wide macros for data width, register count, reset pc and dmem index width
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// ====================
// datapath
// ====================

// data and address width
`define MIPS_XLEN 32

// architectural registers
`define MIPS_NREGS 32

// ====================
// memory map
// ====================

// first fetch after reset
`define MIPS_RESET_PC 32'h0000_0000

// dmem word index, taken from byte address bits 8:2
`define MIPS_DMEM_AW 7

`endif

/* common/mips_isa_pkg.sv */
// isa encodings: opcode and funct enums, register address type, instruction field views
`include "mips_params.svh"

package mips_isa_pkg;

    // ====================
    // encodings
    // ====================

    // primary opcode, bits 31:26
    typedef enum logic [5:0] {
        op_rtype = 6'h00,
        op_j     = 6'h02,
        op_jal   = 6'h03,
        op_beq   = 6'h04,
        op_addi  = 6'h08,
        op_lw    = 6'h23,
        op_sw    = 6'h2b
    } opcode_e;

    // r-type function, bits 5:0
    typedef enum logic [5:0] {
        fn_add = 6'h20,
        fn_sub = 6'h22,
        fn_and = 6'h24,
        fn_or  = 6'h25,
        fn_slt = 6'h2a
    } funct_e;

    typedef logic [$clog2(`MIPS_NREGS)-1:0] reg_addr_t;

    // ====================
    // field views
    // ====================

    typedef struct packed {
        reg_addr_t   rs;
        reg_addr_t   rt;
        reg_addr_t   rd;
        logic [4:0]  shamt;
        funct_e      funct;
    } r_fields_t;

    typedef struct packed {
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm16;
    } i_fields_t;

    typedef struct packed {
        logic [25:0] target26;
    } j_fields_t;

    // the 26 bits below the opcode, seen three ways
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
        j_fields_t j;
    } instr_body_u;

    typedef struct packed {
        opcode_e     opcode;
        instr_body_u body;
    } instr_fields_t;

endpackage

/* common/mips_ctrl_pkg.sv */
// control types: alu operation enum, control word, data memory request and commit structs
`include "mips_params.svh"

package mips_ctrl_pkg;

    // ====================
    // datapath control
    // ====================

    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_slt = 3'd4
    } alu_op_e;

    // one word per instruction, all zero is a nop
    typedef struct packed {
        logic    reg_dst;
        logic    alu_src_imm;
        logic    mem_to_reg;
        logic    reg_write;
        logic    mem_write;
        logic    branch;
        logic    jump;
        logic    link;
        alu_op_e alu_op;
    } ctrl_t;

    // ====================
    // external ports
    // ====================

    // same-cycle data memory port, write lands at the edge
    typedef struct packed {
        logic                     we;
        logic [`MIPS_DMEM_AW-1:0] idx;
        logic [`MIPS_XLEN-1:0]    wdata;
    } dmem_req_t;

    // register write about to retire
    typedef struct packed {
        logic                   valid;
        mips_isa_pkg::reg_addr_t rd;
        logic [`MIPS_XLEN-1:0]  wdata;
    } commit_t;

endpackage

/* src/main_decoder.sv */
// main decoder: opcode and funct to control word, alu control folded in
`timescale 1ns/1ps

module main_decoder (
    input  mips_isa_pkg::opcode_e opcode,
    input  mips_isa_pkg::funct_e  funct,
    output mips_ctrl_pkg::ctrl_t  ctrl
);
    import mips_isa_pkg::*;
    import mips_ctrl_pkg::*;

    always_comb begin
        // anything not listed falls through as a nop
        ctrl        = '0;
        ctrl.alu_op = alu_add;
        case (opcode)
            op_rtype: begin
                ctrl.reg_dst   = 1'b1;
                ctrl.reg_write = 1'b1;
                case (funct)
                    fn_add:  ctrl.alu_op = alu_add;
                    fn_sub:  ctrl.alu_op = alu_sub;
                    fn_and:  ctrl.alu_op = alu_and;
                    fn_or:   ctrl.alu_op = alu_or;
                    fn_slt:  ctrl.alu_op = alu_slt;
                    default: ctrl.reg_write = 1'b0;
                endcase
            end
            op_addi: begin
                ctrl.alu_src_imm = 1'b1;
                ctrl.reg_write   = 1'b1;
            end
            op_lw: begin
                ctrl.alu_src_imm = 1'b1;
                ctrl.mem_to_reg  = 1'b1;
                ctrl.reg_write   = 1'b1;
            end
            op_sw: begin
                ctrl.alu_src_imm = 1'b1;
                ctrl.mem_write   = 1'b1;
            end
            op_beq: begin
                // compare by subtraction
                ctrl.branch = 1'b1;
                ctrl.alu_op = alu_sub;
            end
            op_j: begin
                ctrl.jump = 1'b1;
            end
            op_jal: begin
                ctrl.jump      = 1'b1;
                ctrl.link      = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

endmodule

/* src/alu.sv */
// alu: add, sub, and, or, signed slt, zero flag
`timescale 1ns/1ps
`include "mips_params.svh"

module alu (
    input  logic [`MIPS_XLEN-1:0]  a,
    input  logic [`MIPS_XLEN-1:0]  b,
    input  mips_ctrl_pkg::alu_op_e op,
    output logic [`MIPS_XLEN-1:0]  result,
    output logic                   zero
);
    import mips_ctrl_pkg::*;

    always_comb begin
        case (op)
            alu_add: result = a + b;
            alu_sub: result = a - b;
            alu_and: result = a & b;
            alu_or:  result = a | b;
            alu_slt: begin
                // signed compare, 1 or 0
                result = ($signed(a) < $signed(b)) ? `MIPS_XLEN'd1 : '0;
            end
            default: result = '0;
        endcase
    end

    // whole result, beq relies on it
    assign zero = (result == '0);

    // decoder always hands over a defined operation
    always_comb begin
        assert (!$isunknown(op))
            else $error("alu: op is unknown");
    end

endmodule

/* src/reg_file.sv */
// register file: 32 x 32, two combinational reads, one write port, r0 tied to zero
`timescale 1ns/1ps
`include "mips_params.svh"

module reg_file (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    we,
    input  mips_isa_pkg::reg_addr_t raddr_a,
    input  mips_isa_pkg::reg_addr_t raddr_b,
    input  mips_isa_pkg::reg_addr_t waddr,
    input  logic [`MIPS_XLEN-1:0]   wdata,
    output logic [`MIPS_XLEN-1:0]   rdata_a,
    output logic [`MIPS_XLEN-1:0]   rdata_b
);
    logic [`MIPS_XLEN-1:0] regs [`MIPS_NREGS];

    always_ff @(posedge clk) begin
        if (rst_n) begin
            regs <= '{default: '0};
        end else if (we && (waddr != '0)) begin
            // r0 is never written
            regs[waddr] <= wdata;
        end
    end

    // read ports
    assign rdata_a = regs[raddr_a];
    assign rdata_b = regs[raddr_b];

    // r0 must survive every write the core issues
    r0_stays_zero: assert property (
        @(posedge clk) disable iff (rst_n)
        regs[0] == '0
    ) else $error("reg_file: r0 is not zero");

endmodule

/* core/pc_unit.sv */
// pc unit: program counter register with sequential, branch and jump next-pc selection
`timescale 1ns/1ps
`include "mips_params.svh"

module pc_unit (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  take_branch,
    input  logic                  jump,
    input  logic [`MIPS_XLEN-1:0] imm_ext,
    input  logic [25:0]           target26,
    output logic [`MIPS_XLEN-1:0] pc,
    output logic [`MIPS_XLEN-1:0] pc_plus4
);
    logic [`MIPS_XLEN-1:0] pc_next;
    logic [`MIPS_XLEN-1:0] branch_target;
    logic [`MIPS_XLEN-1:0] jump_target;

    assign pc_plus4 = pc + `MIPS_XLEN'd4;

    // word offset relative to the delay slot address
    assign branch_target = pc_plus4 + {imm_ext[`MIPS_XLEN-3:0], 2'b00};

    // pseudo-direct, keeps the current 256MB region
    assign jump_target = {pc_plus4[`MIPS_XLEN-1:28], target26, 2'b00};

    always_comb begin
        if (jump) begin
            pc_next = jump_target;
        end else if (take_branch) begin
            pc_next = branch_target;
        end else begin
            pc_next = pc_plus4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_n) begin
            pc <= `MIPS_RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    // all targets are built from word offsets
    pc_aligned: assert property (
        @(posedge clk) disable iff (rst_n)
        pc[1:0] == 2'b00
    ) else $error("pc_unit: pc %h not word aligned", pc);

endmodule

/* core/mips_core.sv */
// single-cycle mips core top: field split, operand and write-back muxing, memory and commit ports
`timescale 1ns/1ps
`include "mips_params.svh"

module mips_core (
    input  logic                    clk,
    input  logic                    rst_n,
    output logic [`MIPS_XLEN-1:0]   imem_addr,
    input  logic [`MIPS_XLEN-1:0]   imem_rdata,
    output mips_ctrl_pkg::dmem_req_t dmem_req,
    input  logic [`MIPS_XLEN-1:0]   dmem_rdata,
    output mips_ctrl_pkg::commit_t  commit
);
    import mips_isa_pkg::*;
    import mips_ctrl_pkg::*;

    // ====================
    // decode
    // ====================

    instr_fields_t         instr;
    ctrl_t                 ctrl;
    logic [`MIPS_XLEN-1:0] imm_ext;

    assign instr   = instr_fields_t'(imem_rdata);
    assign imm_ext = {{(`MIPS_XLEN-16){instr.body.i.imm16[15]}}, instr.body.i.imm16};

    main_decoder main_decoder_i (
        .opcode (instr.opcode),
        .funct  (instr.body.r.funct),
        .ctrl   (ctrl)
    );

    // ====================
    // execute
    // ====================

    logic [`MIPS_XLEN-1:0] rdata_a;
    logic [`MIPS_XLEN-1:0] rdata_b;
    logic [`MIPS_XLEN-1:0] alu_b;
    logic [`MIPS_XLEN-1:0] alu_result;
    logic                  alu_zero;
    logic                  take_branch;
    logic [`MIPS_XLEN-1:0] pc;
    logic [`MIPS_XLEN-1:0] pc_plus4;

    assign alu_b       = ctrl.alu_src_imm ? imm_ext : rdata_b;
    assign take_branch = ctrl.branch & alu_zero;

    alu alu_i (
        .a      (rdata_a),
        .b      (alu_b),
        .op     (ctrl.alu_op),
        .result (alu_result),
        .zero   (alu_zero)
    );

    pc_unit pc_unit_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .take_branch (take_branch),
        .jump        (ctrl.jump),
        .imm_ext     (imm_ext),
        .target26    (instr.body.j.target26),
        .pc          (pc),
        .pc_plus4    (pc_plus4)
    );

    assign imem_addr = pc;

    // ====================
    // write-back
    // ====================

    reg_addr_t             wb_addr;
    logic [`MIPS_XLEN-1:0] wb_data;

    always_comb begin
        if (ctrl.link) begin
            // jal links through ra
            wb_addr = reg_addr_t'(31);
            wb_data = pc_plus4;
        end else begin
            wb_addr = ctrl.reg_dst ? instr.body.r.rd : instr.body.r.rt;
            wb_data = ctrl.mem_to_reg ? dmem_rdata : alu_result;
        end
    end

    reg_file reg_file_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .we      (ctrl.reg_write),
        .raddr_a (instr.body.r.rs),
        .raddr_b (instr.body.r.rt),
        .waddr   (wb_addr),
        .wdata   (wb_data),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b)
    );

    // ====================
    // external ports
    // ====================

    // held quiet while in reset
    assign dmem_req.we    = ctrl.mem_write & ~rst_n;
    assign dmem_req.idx   = alu_result[`MIPS_DMEM_AW+1:2];
    assign dmem_req.wdata = rdata_b;

    assign commit.valid = ctrl.reg_write & (wb_addr != '0) & ~rst_n;
    assign commit.rd    = wb_addr;
    assign commit.wdata = wb_data;

    // no instruction in the subset both stores and writes a register
    store_xor_write: assert property (
        @(posedge clk) disable iff (rst_n)
        !(dmem_req.we && commit.valid)
    ) else $error("mips_core: store and register write in one cycle");

    // control transfers never touch data memory
    no_store_on_jump: assert property (
        @(posedge clk) disable iff (rst_n)
        (ctrl.jump || ctrl.branch) |-> !dmem_req.we
    ) else $error("mips_core: store issued by a control transfer");

endmodule

/* bench/mips_iss.svh */
// reference isa model: architectural state, reset and single-step tasks
`ifndef MIPS_ISS_SVH
`define MIPS_ISS_SVH

logic [31:0] model_pc;
logic [31:0] model_regs [32];
logic [31:0] model_dmem [128];

task automatic reset_model();
    model_pc = 32'h0;
    for (int k = 0; k < 32; k++) begin
        model_regs[k] = 32'h0;
    end
endtask

// r0 writes are dropped and never reported
task automatic write_model_reg(input logic [4:0] dst, input logic [31:0] val,
                               inout commit_t c);
    if (dst != 5'd0) begin
        model_regs[dst] = val;
        c.valid = 1'b1;
        c.rd    = dst;
        c.wdata = val;
    end
endtask

// one instruction, returns the register write and the store it makes
task automatic step_model(input logic [31:0] iw, output commit_t c, output dmem_req_t s);
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] addr;
    logic [31:0] pc4;
    logic [31:0] next_pc;
    c = '0;
    s = '0;
    rs = iw[25:21];
    rt = iw[20:16];
    rd = iw[15:11];
    a = model_regs[rs];
    b = model_regs[rt];
    imm = {{16{iw[15]}}, iw[15:0]};
    addr = a + imm;
    pc4 = model_pc + 32'd4;
    next_pc = pc4;
    case (iw[31:26])
        6'h00: begin
            case (iw[5:0])
                6'h20: write_model_reg(rd, a + b, c);
                6'h22: write_model_reg(rd, a - b, c);
                6'h24: write_model_reg(rd, a & b, c);
                6'h25: write_model_reg(rd, a | b, c);
                6'h2a: write_model_reg(rd, {31'd0, $signed(a) < $signed(b)}, c);
                default: ;
            endcase
        end
        6'h08: write_model_reg(rt, addr, c);
        6'h23: write_model_reg(rt, model_dmem[addr[8:2]], c);
        6'h2b: begin
            s.we    = 1'b1;
            s.idx   = addr[8:2];
            s.wdata = b;
            model_dmem[addr[8:2]] = b;
        end
        6'h04: begin
            if (a == b) begin
                next_pc = pc4 + {imm[29:0], 2'b00};
            end
        end
        6'h02: next_pc = {pc4[31:28], iw[25:0], 2'b00};
        6'h03: begin
            next_pc = {pc4[31:28], iw[25:0], 2'b00};
            write_model_reg(5'd31, pc4, c);
        end
        default: ;
    endcase
    model_pc = next_pc;
endtask

`endif

/* bench/tb_mips_core.sv */
// clock, reset, lfsr program, memory models, reference model and checks for mips_core
`timescale 1ns/1ps
`include "mips_params.svh"

module tb_mips_core;
    import mips_ctrl_pkg::*;

    localparam int PROG_WORDS    = 64;
    localparam int IMEM_WORDS    = 256;
    localparam int DMEM_WORDS    = 128;
    localparam int SEG_BASE      = 64;
    localparam int RANDOM_CYCLES = 400;
    localparam int READBACK_MAX  = 200;
    localparam logic [31:0] SEG_END     = 32'd768;
    localparam logic [31:0] JUMP_TO_SEG = {6'h02, 26'd64};
    // sw r0, 0(r0) and addi r1, r0, 1 placed at the reset pc
    localparam logic [31:0] RESET_STORE = {6'h2b, 5'd0, 5'd0, 16'd0};
    localparam logic [31:0] RESET_WRITE = {6'h08, 5'd0, 5'd1, 16'd1};

    logic                  clk;
    logic                  rst_n;
    logic [`MIPS_XLEN-1:0] imem_addr;
    logic [`MIPS_XLEN-1:0] imem_rdata;
    dmem_req_t             dmem_req;
    logic [`MIPS_XLEN-1:0] dmem_rdata;
    commit_t               commit;

    logic [31:0] imem [IMEM_WORDS];
    logic [31:0] dmem [DMEM_WORDS];
    logic [31:0] lfsr_state = 32'h3e49_3a70;
    int          checks = 0;
    int          errors = 0;

    `include "mips_iss.svh"

    mips_core mips_core_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata),
        .commit     (commit)
    );

    // outside the image a fetch reads as nop
    assign imem_rdata = (imem_addr[31:10] == '0) ? imem[imem_addr[9:2]] : '0;
    assign dmem_rdata = dmem[dmem_req.idx];

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // ====================
    // stimulus
    // ====================

    // galois lfsr stepped once per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int k = 0; k < n; k++) begin
            bits = {bits[30:0], lfsr_state[0]};
            lfsr_state = {1'b0, lfsr_state[31:1]} ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
        end
        return bits;
    endfunction

    function automatic logic [4:0] rand_reg();
        logic [31:0] bits;
        bits = take_bits(5);
        return bits[4:0];
    endfunction

    // word inside the image other than w itself
    function automatic int rand_target(input int w);
        logic [31:0] bits;
        int t;
        bits = take_bits(6);
        t = int'(bits[5:0]);
        if (t == w) begin
            t = (w + 1) % PROG_WORDS;
        end
        return t;
    endfunction

    function automatic logic [31:0] gen_instr(input int w);
        logic [31:0] kind;
        logic [31:0] bits;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        int          t;
        int          off;
        kind = take_bits(4);
        rs = rand_reg();
        rt = rand_reg();
        rd = rand_reg();
        bits = take_bits(16);
        case (kind[3:0])
            4'd1: return {6'h00, rs, rt, rd, 5'd0, 6'h22};
            4'd2: return {6'h00, rs, rt, rd, 5'd0, 6'h24};
            4'd3: return {6'h00, rs, rt, rd, 5'd0, 6'h25};
            4'd4: return {6'h00, rs, rt, rd, 5'd0, 6'h2a};
            4'd5, 4'd6: return {6'h08, rs, rt, bits[15:0]};
            // base r0 with a word offset below 512
            4'd7, 4'd8: return {6'h23, 5'd0, rt, 7'd0, bits[6:0], 2'b00};
            4'd9, 4'd10: return {6'h2b, 5'd0, rt, 7'd0, bits[6:0], 2'b00};
            4'd11, 4'd12: begin
                t = rand_target(w);
                off = t - (w + 1);
                return {6'h04, rs, rt, off[15:0]};
            end
            4'd13: begin
                t = rand_target(w);
                return {6'h02, t[25:0]};
            end
            4'd14: begin
                t = rand_target(w);
                return {6'h03, t[25:0]};
            end
            default: return {6'h00, rs, rt, rd, 5'd0, 6'h20};
        endcase
    endfunction

    // random image and closing jump followed by the lw readback segment
    task automatic load_program();
        logic [31:0] v;
        int          t;
        int          k;
        for (int w = 0; w < IMEM_WORDS; w++) begin
            if (w < PROG_WORDS - 1) begin
                v = gen_instr(w);
            end else if (w == PROG_WORDS - 1) begin
                t = rand_target(w);
                v = {6'h02, t[25:0]};
            end else if (w < SEG_BASE + DMEM_WORDS) begin
                k = w - SEG_BASE;
                t = (k % 31) + 1;
                v = {6'h23, 5'd0, t[4:0], 7'd0, k[6:0], 2'b00};
            end else begin
                v = 32'h0;
            end
            imem[w] <= v;
        end
        for (k = 0; k < DMEM_WORDS; k++) begin
            v = take_bits(32);
            dmem[k] <= v;
            model_dmem[k] = v;
        end
    endtask

    // ====================
    // checks
    // ====================

    task automatic check_pc(input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("MISMATCH imem_addr got %h expected %h", got, exp);
            errors++;
        end
    endtask

    task automatic check_commit(input commit_t got, input commit_t exp);
        checks++;
        if (got.valid !== exp.valid) begin
            $display("MISMATCH commit.valid got %h expected %h at pc %h",
                     got.valid, exp.valid, imem_addr);
            errors++;
        end else if (exp.valid && got.rd !== exp.rd) begin
            $display("MISMATCH commit.rd got %h expected %h at pc %h", got.rd, exp.rd, imem_addr);
            errors++;
        end else if (exp.valid && got.wdata !== exp.wdata) begin
            $display("MISMATCH commit.wdata got %h expected %h at pc %h",
                     got.wdata, exp.wdata, imem_addr);
            errors++;
        end
    endtask

    // idx and wdata only matter on a store
    task automatic check_store(input dmem_req_t got, input dmem_req_t exp);
        checks++;
        if (got.we !== exp.we) begin
            $display("MISMATCH dmem_req.we got %h expected %h at pc %h", got.we, exp.we, imem_addr);
            errors++;
        end else if (exp.we && got.idx !== exp.idx) begin
            $display("MISMATCH dmem_req.idx got %h expected %h", got.idx, exp.idx);
            errors++;
        end else if (exp.we && got.wdata !== exp.wdata) begin
            $display("MISMATCH dmem_req.wdata got %h expected %h", got.wdata, exp.wdata);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int first_err);
        $display("test %s done, %0d errors", name, errors - first_err);
    endtask

    // entered at a falling edge and left at the next one
    task automatic run_cycle(input logic switch_image);
        commit_t   exp_commit;
        dmem_req_t exp_store;
        dmem_req_t pending;
        check_pc(imem_addr, model_pc);
        step_model(model_fetch(model_pc), exp_commit, exp_store);
        check_commit(commit, exp_commit);
        check_store(dmem_req, exp_store);
        pending = dmem_req;
        @(posedge clk);
        if (pending.we) begin
            dmem[pending.idx] <= pending.wdata;
        end
        if (switch_image) begin
            for (int w = 0; w < PROG_WORDS; w++) begin
                imem[w] <= JUMP_TO_SEG;
            end
        end
        @(negedge clk);
    endtask

    function automatic logic [31:0] model_fetch(input logic [31:0] addr);
        if (addr[31:10] != '0) begin
            return 32'h0;
        end
        return imem[addr[9:2]];
    endfunction

    // ====================
    // test sequence
    // ====================

    initial begin
        int          cyc;
        int          first_err;
        logic        timed_out;
        logic [31:0] first_word;
        rst_n <= 1'b1;
        load_program();
        reset_model();

        // stores and commits stay quiet in reset
        // the reset pc sees a store and then a register write
        first_err = errors;
        for (cyc = 0; cyc < 4; cyc++) begin
            @(posedge clk);
            if (cyc == 0) begin
                first_word = imem[0];
                imem[0] <= RESET_STORE;
            end else if (cyc == 1) begin
                imem[0] <= RESET_WRITE;
            end else if (cyc == 2) begin
                imem[0] <= first_word;
            end else begin
                rst_n <= 1'b0;
            end
            @(negedge clk);
            if (cyc < 3) begin
                check_commit(commit, '0);
                check_store(dmem_req, '0);
            end
        end
        check_pc(imem_addr, `MIPS_RESET_PC);
        report_test("reset", first_err);

        first_err = errors;
        for (cyc = 0; cyc < RANDOM_CYCLES; cyc++) begin
            run_cycle(cyc == RANDOM_CYCLES - 1);
        end
        report_test("random_program", first_err);

        first_err = errors;
        cyc = 0;
        while (model_pc != SEG_END && cyc < READBACK_MAX) begin
            run_cycle(1'b0);
            cyc++;
        end
        timed_out = (model_pc != SEG_END);

        if (timed_out) begin
            $display("readback segment did not finish within %0d cycles", READBACK_MAX);
        end else begin
            report_test("readback", first_err);
        end
        $display("3 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+common
+incdir+bench
common/mips_isa_pkg.sv
common/mips_ctrl_pkg.sv
src/main_decoder.sv
src/alu.sv
src/reg_file.sv
core/pc_unit.sv
core/mips_core.sv
bench/tb_mips_core.sv

/* run_sim.sh */
#!/bin/sh
# build with verilator, run, and grade the run from its log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_mips_core -f vlog.f \
    || { echo "verilator build failed"; exit 1; }
./obj_dir/Vtb_mips_core > sim.log 2>&1 || echo "simulator returned an error status"
cat sim.log
grep -q "^Simulation finished: PASS$" sim.log && echo "run passed" \
    || { echo "run failed"; exit 1; }
